// File: verilog/dspPkg.sv
`default_nettype none

// datapath description shared by the slices and the column top level
package dspPkg;

  // operand width of the multiplier inputs
  localparam int opWidth = 8;

  // full product of two operands
  localparam int prodWidth = 2 * opWidth;

  // adder, accumulator and result width, wraps on overflow
  localparam int accWidth = 20;

  // multiplier operand pair, a in the upper byte
  typedef struct packed {
    logic [opWidth-1:0] a; // multiplicand
    logic [opWidth-1:0] b; // multiplier
  } mulOperands;

  // word carried on c, q and the accumulators
  typedef logic [accWidth-1:0] accWord;

endpackage

`default_nettype wire

// File: verilog/cfgPkg.sv
`default_nettype none

// configuration layout of the column
package cfgPkg;

  // per-slice mode flags, bit 0 is regA and bit 5 is accOut
  typedef struct packed {
    logic accOut;      // q shows the accumulator instead of the live sum
    logic signExt;     // sign-extend the product to accWidth
    logic accFeedback; // addend is the accumulator, not c
    logic regC;        // use the registered c operand
    logic regB;        // use the registered b operand
    logic regA;        // use the registered a operand
  } sliceMode;

  // width of one slice's mode field
  localparam int modeBits = 6;

  // full frame for the two-slice column
  localparam int cfgBits = 2 * modeBits;

  // the two slice fields, slice1 sits on the upper bits
  typedef struct packed {
    sliceMode slice1;
    sliceMode slice0;
  } cfgFields;

  // same 12 bits seen as the shift vector or as slice fields
  typedef union packed {
    logic [cfgBits-1:0] raw; // what the loader shifts
    cfgFields fields;        // what the slices read
  } cfgWord;

endpackage

`default_nettype wire

// File: verilog/cfgFrameLoader.sv
`timescale 1ns/1ps
`default_nettype none

// serial config loader
// bits are shifted into a shadow register and only reach the
// slices when cfgLatch copies the whole frame across
module cfgFrameLoader #(
  parameter int numSlices = 2
) (
  input  wire logic           UserCLK,
  input  wire logic           rstN,
  input  wire logic           cfgShift,  // shift cfgData in on this edge
  input  wire logic           cfgData,   // serial config bit
  input  wire logic           cfgLatch,  // copy the shadow frame to the slices
  output cfgPkg::cfgWord      activeCfg  // modes in effect
);

  localparam int frameBits = numSlices * cfgPkg::modeBits; // total config bits

  logic [frameBits-1:0] shadowReg; // frame under construction
  logic [frameBits-1:0] activeReg; // frame driving the slices

  // shift register, new bit enters at bit 0
  // after a full frame the first bit sent is at the top
  always_ff @(posedge UserCLK or negedge rstN) begin
    if (!rstN) begin
      shadowReg <= '0;
    end else if (cfgShift) begin
      shadowReg <= {shadowReg[frameBits-2:0], cfgData};
    end
  end

  // latched copy, all slices switch mode on the same edge
  always_ff @(posedge UserCLK or negedge rstN) begin
    if (!rstN) begin
      activeReg <= '0; // live, unsigned, no accumulation
    end else if (cfgLatch) begin
      activeReg <= shadowReg;
    end
  end

  assign activeCfg.raw = activeReg; // raw view, top level decodes the fields

  // a latch in a shift cycle would capture a half-moved frame
  shiftLatchExclusive: assert property (
    @(posedge UserCLK) disable iff (!rstN)
    !(cfgShift && cfgLatch)
  ) else $error("cfgShift and cfgLatch high in the same cycle");

endmodule

`default_nettype wire

// File: verilog/mulAdd.sv
`timescale 1ns/1ps
`default_nettype none

// one multiply-add slice
// q = a*b + (c or accumulator), each operand optionally registered
module mulAdd (
  input  wire logic              UserCLK,
  input  wire logic              rstN,
  input  dspPkg::mulOperands     ops,  // a and b
  input  dspPkg::accWord         c,    // addend / cascade input
  input  wire logic              clr,  // zero the accumulator on this edge
  input  cfgPkg::sliceMode       mode, // latched mode flags
  output dspPkg::accWord         q     // result
);

  localparam int extBits = dspPkg::accWidth - dspPkg::prodWidth; // product pad bits

  logic [dspPkg::opWidth-1:0]   aReg;   // registered a
  logic [dspPkg::opWidth-1:0]   bReg;   // registered b
  dspPkg::accWord               cReg;   // registered c
  dspPkg::accWord               accReg; // accumulator

  logic [dspPkg::opWidth-1:0]   opA;    // a after mux
  logic [dspPkg::opWidth-1:0]   opB;    // b after mux
  dspPkg::accWord               opC;    // c after mux
  logic [dspPkg::prodWidth-1:0] product;
  dspPkg::accWord               productExt; // product widened to accWidth
  dspPkg::accWord               addend;
  dspPkg::accWord               sum;

  // operand registers load every edge, the mode picks whether they are used
  always_ff @(posedge UserCLK or negedge rstN) begin
    if (!rstN) begin
      aReg <= '0;
      bReg <= '0;
      cReg <= '0;
    end else begin
      aReg <= ops.a;
      bReg <= ops.b;
      cReg <= c;
    end
  end

  // live or one-cycle-late operands
  assign opA = mode.regA ? aReg : ops.a;
  assign opB = mode.regB ? bReg : ops.b;
  assign opC = mode.regC ? cReg : c;

  // unsigned 8x8 with both operands zero padded to the product width
  assign product = {{dspPkg::opWidth{1'b0}}, opA} * {{dspPkg::opWidth{1'b0}}, opB};

  // upper pad is zeros, or copies of the product msb
  always_comb begin
    if (mode.signExt) begin
      productExt = {{extBits{product[dspPkg::prodWidth-1]}}, product};
    end else begin
      productExt = {{extBits{1'b0}}, product};
    end
  end

  assign addend = mode.accFeedback ? accReg : opC; // running total or c

  assign sum = productExt + addend; // wraps at accWidth, no overflow flag

  // accumulator follows the sum every edge unless cleared
  always_ff @(posedge UserCLK or negedge rstN) begin
    if (!rstN) begin
      accReg <= '0;
    end else if (clr) begin
      accReg <= '0;
    end else begin
      accReg <= sum;
    end
  end

  assign q = mode.accOut ? accReg : sum; // accOut puts q one cycle behind

  // unknowns on q would spread through the cascade to the next slice
  qKnown: assert property (
    @(posedge UserCLK) disable iff (!rstN)
    !$isunknown(q)
  ) else $error("q has unknown bits: %h", q);

endmodule

`default_nettype wire

// File: verilog/dspColumn.sv
`timescale 1ns/1ps
`default_nettype none

// dsp column: config loader plus two multiply-add slices
// slice1 takes q0 as its c operand so the column chains a*b+c
module dspColumn #(
  parameter int numSlices = 2
) (
  input  wire logic          UserCLK,
  input  wire logic          rstN,
  input  wire logic          cfgShift, // serial config strobe
  input  wire logic          cfgData,  // serial config bit
  input  wire logic          cfgLatch, // apply shifted frame
  input  dspPkg::mulOperands ops0,     // slice0 a and b
  input  dspPkg::mulOperands ops1,     // slice1 a and b
  input  dspPkg::accWord     c0,       // slice0 addend
  input  wire logic          clr0,     // slice0 accumulator clear
  input  wire logic          clr1,     // slice1 accumulator clear
  output dspPkg::accWord     q0,
  output dspPkg::accWord     q1
);

  cfgPkg::cfgWord activeCfg; // both slices' modes, read through the field view

  // shadow/active config frame
  cfgFrameLoader #(
    .numSlices (numSlices)
  ) loader (
    .UserCLK   (UserCLK),
    .rstN      (rstN),
    .cfgShift  (cfgShift),
    .cfgData   (cfgData),
    .cfgLatch  (cfgLatch),
    .activeCfg (activeCfg)
  );

  // first slice, c from the pins
  mulAdd slice0 (
    .UserCLK (UserCLK),
    .rstN    (rstN),
    .ops     (ops0),
    .c       (c0),
    .clr     (clr0),
    .mode    (activeCfg.fields.slice0),
    .q       (q0)
  );

  // second slice, c is the cascade from q0
  // no delay on the chain unless slice1 sets regC
  mulAdd slice1 (
    .UserCLK (UserCLK),
    .rstN    (rstN),
    .ops     (ops1),
    .c       (q0),
    .clr     (clr1),
    .mode    (activeCfg.fields.slice1),
    .q       (q1)
  );

  // the cascade above is wired for exactly two slices
  twoSlices: assert property (
    @(posedge UserCLK) numSlices == 2
  ) else $error("dspColumn built for 2 slices, numSlices is %0d", numSlices);

endmodule

`default_nettype wire

// File: bench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

// free running testbench clock, starts low
module tbClock #(
  parameter int periodNs = 100 // full clock period in ns
) (
  output logic UserCLK
);

  initial UserCLK = 1'b0;

  always #(periodNs / 2) UserCLK = ~UserCLK; // half period per toggle

endmodule

`default_nettype wire

// File: bench/dspColumnTb.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the dsp column
// every step comes from one line of bench/dspColumnTests.txt
module dspColumnTb;

  localparam int clkPeriod     = 100;               // ns
  localparam int checkDelay    = clkPeriod * 2 / 5; // after the falling edge, before the rising one
  localparam int maxTests      = 64;                // room in the vector memory
  localparam int cyclesPerTest = 20;                // watchdog budget per vector
  localparam int cyclesSpare   = 10;                // reset and slack

  // opcodes in the first column of the data file
  localparam logic [3:0] opConfig = 4'h1; // shift a frame and latch it
  localparam logic [3:0] opApply  = 4'h2; // drive operands, check q0 and q1
  localparam logic [3:0] opShift  = 4'h3; // shift a frame without latching
  localparam logic [3:0] opLatch  = 4'h4; // latch the shadow frame only

  // one line of the data file, fields nibble aligned
  typedef struct packed {
    logic [3:0]         op;
    cfgPkg::cfgWord     cfg;  // frame for config lines
    dspPkg::mulOperands ops0;
    dspPkg::mulOperands ops1;
    dspPkg::accWord     c0;
    logic [3:0]         clr0; // only bit 0 used
    logic [3:0]         clr1; // only bit 0 used
    dspPkg::accWord     q0;   // expected q0
    dspPkg::accWord     q1;   // expected q1
  } testVector;

  logic               UserCLK;
  logic               rstN;
  logic               cfgShift;
  logic               cfgData;
  logic               cfgLatch;
  dspPkg::mulOperands ops0;
  dspPkg::mulOperands ops1;
  dspPkg::accWord     c0;
  logic               clr0;
  logic               clr1;
  dspPkg::accWord     q0;
  dspPkg::accWord     q1;

  logic [$bits(testVector)-1:0] vecMem [0:maxTests-1]; // raw lines from the file
  int numTests = 0; // valid vectors, set once the file is read

  tbClock #(
    .periodNs (clkPeriod)
  ) clockGen (
    .UserCLK (UserCLK)
  );

  dspColumn #(
    .numSlices (2)
  ) dspColumn_i (
    .UserCLK  (UserCLK),
    .rstN     (rstN),
    .cfgShift (cfgShift),
    .cfgData  (cfgData),
    .cfgLatch (cfgLatch),
    .ops0     (ops0),
    .ops1     (ops1),
    .c0       (c0),
    .clr0     (clr0),
    .clr1     (clr1),
    .q0       (q0),
    .q1       (q1)
  );

  // operands zero and accumulators cleared while a frame moves
  task automatic quietOperands();
    ops0 = '0;
    ops1 = '0;
    c0   = '0;
    clr0 = 1'b1;
    clr1 = 1'b1;
  endtask

  // msb first, so the first bit sent lands in bit 11
  task automatic shiftFrame(input cfgPkg::cfgWord frame);
    cfgPkg::cfgWord rest;
    rest = frame;
    repeat (cfgPkg::cfgBits) begin
      @(negedge UserCLK);
      quietOperands();
      cfgLatch = 1'b0;
      cfgShift = 1'b1;
      cfgData  = rest.raw[cfgPkg::cfgBits-1];
      rest.raw = rest.raw << 1; // next bit to the top
    end
  endtask

  // one latch strobe, new modes from the following rising edge
  task automatic latchFrame();
    @(negedge UserCLK);
    quietOperands();
    cfgShift = 1'b0;
    cfgData  = 1'b0;
    cfgLatch = 1'b1;
  endtask

  task automatic applyAndCheck(input testVector v, input int vecNo);
    @(negedge UserCLK);
    cfgShift = 1'b0;
    cfgData  = 1'b0;
    cfgLatch = 1'b0;
    ops0     = v.ops0;
    ops1     = v.ops1;
    c0       = v.c0;
    clr0     = v.clr0[0];
    clr1     = v.clr1[0];
    #(checkDelay); // outputs settled, next rising edge still ahead
    assert (q0 === v.q0) else begin
      $display("** Error: q0 = %h, expected %h at vector %0d", q0, v.q0, vecNo);
      $display("tests failed");
      $fatal(1, "q0 mismatch");
    end
    assert (q1 === v.q1) else begin
      $display("** Error: q1 = %h, expected %h at vector %0d", q1, v.q1, vecNo);
      $display("tests failed");
      $fatal(1, "q1 mismatch");
    end
  endtask

  initial begin : mainSequence
    testVector vec;
    int        vecCount;
    rstN     = 1'b0; // all DUT inputs known from time 0
    cfgShift = 1'b0;
    cfgData  = 1'b0;
    cfgLatch = 1'b0;
    ops0     = '0;
    ops1     = '0;
    c0       = '0;
    clr0     = 1'b0;
    clr1     = 1'b0;

    for (int i = 0; i < maxTests; i++) begin
      vecMem[i] = '0; // opcode 0 marks the end of the list
    end
    $readmemh("bench/dspColumnTests.txt", vecMem);
    vecCount = 0;
    for (int i = 0; i < maxTests; i++) begin
      vec = vecMem[i];
      if (vec.op == 4'h0) begin
        break;
      end
      vecCount = i + 1;
    end
    numTests = vecCount; // watchdog budget starts from the full count
    assert (numTests != 0) else begin
      $display("no test vectors could be read from bench/dspColumnTests.txt");
      $display("tests failed");
      $fatal(1, "empty vector file");
    end

    repeat (3) @(posedge UserCLK); // reset over three cycles
    @(negedge UserCLK);
    rstN = 1'b1;

    for (int i = 0; i < numTests; i++) begin
      vec = vecMem[i];
      case (vec.op)
        opConfig: begin
          shiftFrame(vec.cfg);
          latchFrame();
        end
        opShift: shiftFrame(vec.cfg);
        opLatch: latchFrame();
        opApply: applyAndCheck(vec, i + 1);
        default: begin
          $display("vector %0d holds an unknown opcode %h", i + 1, vec.op);
          $display("tests failed");
          $fatal(1, "bad vector file");
        end
      endcase
    end

    $display("all tests passed");
    $finish;
  end

  // a stuck run ends here, budget scales with the vector count
  initial begin : watchdog
    wait (numTests != 0);
    repeat (numTests * cyclesPerTest + cyclesSpare) @(posedge UserCLK);
    $display("timeout: the run did not finish within %0d clock cycles",
             numTests * cyclesPerTest + cyclesSpare);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: bench/dspColumnTests.txt
// op_cfg_ops0_ops1_c0_clr0_clr1_q0_q1, ops are a then b, q0 and q1 are expected
// op 1 shift and latch, 2 apply and check, 3 shift only, 4 latch only
// live path straight out of reset
2_000_0305_0207_00010_0_0_0001F_0002D
2_000_FFFF_0F0F_FFFF0_0_0_0FDF1_0FED2
2_000_8081_0000_00001_0_0_04081_04081
// slice0 uses registered a, b and c
1_007_0000_0000_00000_0_0_00000_00000
2_000_0203_0102_00100_0_0_00000_00002
2_000_0405_0303_00200_0_0_00106_0010F
2_000_0000_0A0B_00000_0_0_00214_00282
// slice1 registers the cascade from q0
1_100_0000_0000_00000_0_0_00000_00000
2_000_0203_0101_00000_0_0_00006_00001
2_000_0404_0202_00010_0_0_00020_0000A
2_000_0000_0000_00000_0_0_00000_00020
// slice0 accumulates, q0 shows the accumulator
1_028_0000_0000_00000_0_0_00000_00000
2_000_0304_0102_00000_0_0_00000_00002
2_000_0506_0000_00000_0_0_0000C_0000C
2_000_1010_0101_00000_0_0_0002A_0002B
2_000_0202_0000_00000_1_0_0012A_0012A
2_000_0303_0000_00000_0_0_00000_00000
2_000_0000_0000_00000_0_0_00009_00009
// sign extension on slice0
1_010_0000_0000_00000_0_0_00000_00000
2_000_8081_0000_00000_0_0_04080_04080
2_000_C0C0_0102_00010_0_0_F9010_F9012
2_000_FFFF_0000_00200_0_0_00001_00001
// sign extension off again
1_000_0000_0000_00000_0_0_00000_00000
2_000_C0C0_0102_00010_0_0_09010_09012
// accumulate mode shifted in, still live until the latch
3_028_0000_0000_00000_0_0_00000_00000
2_000_0304_0000_00001_0_0_0000D_0000D
2_000_0102_0000_00000_0_0_00002_00002
4_000_0000_0000_00000_0_0_00000_00000
2_000_0304_0000_00000_0_0_00000_00000
2_000_0506_0000_00000_0_0_0000C_0000C
2_000_0000_0000_00000_0_0_0002A_0002A

// File: dspColumn.f
verilog/dspPkg.sv
verilog/cfgPkg.sv
verilog/cfgFrameLoader.sv
verilog/mulAdd.sv
verilog/dspColumn.sv
bench/tbClock.sv
bench/dspColumnTb.sv

// File: runSim.sh
#!/bin/sh
# compile and run the dspColumn testbench with Verilator
# the verdict comes from the pass line in the log

cd "$(dirname "$0")" || exit 1 # paths are relative to the project root

buildDir=obj_dir
simExe=dspColumnSim
logFile=sim.log

verilator --binary --timing --assert \
  -f dspColumn.f \
  --top-module dspColumnTb \
  -Mdir "$buildDir" \
  -o "$simExe"
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

"./$buildDir/$simExe" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

# exact line match, so no other output can pass by accident
if grep -qx "all tests passed" "$logFile"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi
